// File: hdl/audio_pkg.sv
`default_nettype none

package audio_pkg;

  // Datapath widths
  localparam int SAMPLE_W = 16;  // Signed PCM sample
  localparam int ENERGY_W = 32;
  localparam int FCNT_W   = 8;

  // Host bus
  localparam int WB_ADR_W = 4;  // Word address
  localparam int WB_DAT_W = 32;

  localparam int SLOT_BITS = 32;  // sck cycles per I2S channel slot

  // Register field positions
  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_CLR_BIT  = 1;  // Write-one pulse, reads 0
  localparam int STAT_DET_BIT  = 0;
  localparam int STAT_FCNT_LSB = 8;

  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL   = 4'd0,
    REG_THRESH = 4'd1,
    REG_ENERGY = 4'd2,  // Read-only
    REG_STATUS = 4'd3   // Read-only
  } reg_addr_e;

endpackage

`default_nettype wire

// File: hdl/detect_cfg_if.sv
`default_nettype none

// Configuration and results between the register file and the detector
interface detect_cfg_if
  import audio_pkg::*;
();

  logic [ENERGY_W-1:0] threshold;
  logic                enable;
  logic                clear_pulse;  // One cycle wide
  logic [ENERGY_W-1:0] energy;       // Last completed frame
  logic [FCNT_W-1:0]   frame_count;
  logic                detected;
  logic                frame_done;

  modport regs (
    output threshold, enable, clear_pulse,
    input  energy, frame_count, detected, frame_done
  );

  modport det (
    input  threshold, enable, clear_pulse,
    output energy, frame_count, detected, frame_done
  );

endinterface

`default_nettype wire

// File: hdl/mic_i2s_rx.sv
`default_nettype none

module mic_i2s_rx
  import audio_pkg::*;
#(
  parameter int SCK_DIV = 4
) (
  input  wire                         clk_m,
  input  wire                         sys_rst,
  input  wire                         mic_data,
  output logic                        mic_sck,
  output logic                        mic_ws,
  output logic signed [SAMPLE_W-1:0]  sample,
  output logic                        sample_valid
);

  localparam int DIV_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;
  localparam int BIT_W = $clog2(2 * SLOT_BITS);
  // MSB sits one sck cycle after the ws edge
  localparam logic [BIT_W-1:0] FIRST_BIT = BIT_W'(1);
  localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(SAMPLE_W);

  typedef enum logic [1:0] {IDLE_SLOT, SHIFT, DONE} state_e;

  logic [DIV_W-1:0]    div_cnt;
  logic [BIT_W-1:0]    bit_cnt;  // sck cycle within the stereo frame
  logic [BIT_W-1:0]    bit_nxt;
  logic                div_wrap;
  logic                sck_rise;
  logic                sck_fall;
  logic                shift_en;
  logic [SAMPLE_W-1:0] shreg;
  state_e              state;

  assign div_wrap = (div_cnt == DIV_W'(SCK_DIV - 1));
  assign sck_rise = div_wrap && !mic_sck;  // sck goes high at this edge
  assign sck_fall = div_wrap && mic_sck;
  assign bit_nxt  = (bit_cnt == BIT_W'(2 * SLOT_BITS - 1)) ? '0 : bit_cnt + 1'b1;

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      div_cnt <= '0;
      mic_sck <= 1'b0;
      bit_cnt <= '0;
      mic_ws  <= 1'b0;
    end else begin
      if (div_wrap) begin
        div_cnt <= '0;
        mic_sck <= ~mic_sck;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (sck_fall) begin
        bit_cnt <= bit_nxt;
        mic_ws  <= (bit_nxt >= BIT_W'(SLOT_BITS));  // High half is right slot
      end
    end
  end

  assign shift_en = sck_rise &&
                    ((state == IDLE_SLOT && bit_cnt == FIRST_BIT) || state == SHIFT);

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      state        <= IDLE_SLOT;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      case (state)
        IDLE_SLOT: if (shift_en) state <= SHIFT;
        SHIFT:     if (sck_rise && bit_cnt == LAST_BIT) state <= DONE;
        DONE: begin
          sample_valid <= 1'b1;
          state        <= IDLE_SLOT;
        end
        default:   state <= IDLE_SLOT;
      endcase
    end
  end

  always_ff @(posedge clk_m) begin
    if (shift_en) shreg <= {shreg[SAMPLE_W-2:0], mic_data};  // MSB first
    if (state == DONE) sample <= shreg;
  end

  // Valid is a strobe, one per stereo frame
  assert property (@(posedge clk_m) disable iff (sys_rst) sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

// File: hdl/pdm_mod.sv
`default_nettype none

module pdm_mod
  import audio_pkg::*;
(
  input  wire                        clk_m,
  input  wire                        sys_rst,
  input  wire signed [SAMPLE_W-1:0]  sample,
  input  wire                        sample_valid,
  output logic                       pdm_out
);

  logic [SAMPLE_W-1:0] level;  // Offset binary copy of the last sample
  logic [SAMPLE_W-1:0] acc;
  logic [SAMPLE_W:0]   sum;

  // Carry out is the density-coded bit
  assign sum = {1'b0, acc} + {1'b0, level};

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      level   <= '0;
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      if (sample_valid) begin
        level <= {~sample[SAMPLE_W-1], sample[SAMPLE_W-2:0]};  // Flip sign bit
      end
      acc     <= sum[SAMPLE_W-1:0];
      pdm_out <= sum[SAMPLE_W];
    end
  end

endmodule

`default_nettype wire

// File: hdl/frame_energy.sv
`default_nettype none

module frame_energy
  import audio_pkg::*;
#(
  parameter int FRAME_LEN = 512
) (
  input  wire                        clk_m,
  input  wire                        sys_rst,
  input  wire signed [SAMPLE_W-1:0]  sample,
  input  wire                        sample_valid,
  detect_cfg_if.det                  cfg
);

  localparam int IDX_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_LEN - 1);

  logic [IDX_W-1:0]    idx;  // Samples already in this frame
  logic [SAMPLE_W-1:0] abs_val;
  logic [ENERGY_W-1:0] acc;
  logic [ENERGY_W:0]   sum_wide;
  logic [ENERGY_W-1:0] sum_next;
  logic                frame_end;

  // Unsigned result, so -32768 maps to 32768
  assign abs_val = sample[SAMPLE_W-1] ? SAMPLE_W'(-sample) : SAMPLE_W'(sample);

  assign sum_wide  = {1'b0, acc} + (ENERGY_W + 1)'(abs_val);
  assign sum_next  = sum_wide[ENERGY_W-1:0];
  assign frame_end = sample_valid && (idx == LAST_IDX);

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      idx             <= '0;
      acc             <= '0;
      cfg.energy      <= '0;
      cfg.frame_count <= '0;
      cfg.detected    <= 1'b0;
      cfg.frame_done  <= 1'b0;
    end else begin
      cfg.frame_done <= 1'b0;
      if (cfg.clear_pulse) begin  // Host clear wins over a sample
        idx             <= '0;
        acc             <= '0;
        cfg.frame_count <= '0;
        cfg.detected    <= 1'b0;
      end else if (frame_end) begin
        idx             <= '0;
        acc             <= '0;  // Next frame starts from zero
        cfg.energy      <= sum_next;
        cfg.frame_count <= cfg.frame_count + 1'b1;
        cfg.detected    <= cfg.enable && (sum_next > cfg.threshold);
        cfg.frame_done  <= 1'b1;
      end else if (sample_valid) begin
        idx <= idx + 1'b1;
        acc <= sum_next;
      end
    end
  end

  // A frame of full-scale samples must still fit the energy width
  assert property (@(posedge clk_m) disable iff (sys_rst)
    sample_valid |-> !sum_wide[ENERGY_W]);

endmodule

`default_nettype wire

// File: hdl/wb_regs.sv
`default_nettype none

module wb_regs
  import audio_pkg::*;
(
  input  wire                 clk_m,
  input  wire                 sys_rst,
  input  wire                 wb_cyc,
  input  wire                 wb_stb,
  input  wire                 wb_we,
  input  wire [WB_ADR_W-1:0]  wb_adr,
  input  wire [WB_DAT_W-1:0]  wb_dat_w,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack,
  detect_cfg_if.regs          cfg
);

  logic                req;  // New access, not yet acknowledged
  reg_addr_e           addr;
  logic [WB_DAT_W-1:0] rd_data;

  assign req  = wb_cyc && wb_stb && !wb_ack;
  assign addr = reg_addr_e'(wb_adr);

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      wb_ack          <= 1'b0;
      cfg.enable      <= 1'b0;
      cfg.threshold   <= '0;
      cfg.clear_pulse <= 1'b0;
    end else begin
      wb_ack          <= req;  // Single-cycle ack, no wait states
      cfg.clear_pulse <= 1'b0;
      if (req && wb_we) begin
        case (addr)
          REG_CTRL: begin
            cfg.enable      <= wb_dat_w[CTRL_EN_BIT];
            cfg.clear_pulse <= wb_dat_w[CTRL_CLR_BIT];
          end
          REG_THRESH: cfg.threshold <= ENERGY_W'(wb_dat_w);
          default: ;  // Results are read-only
        endcase
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (addr)
      REG_CTRL:   rd_data[CTRL_EN_BIT] = cfg.enable;  // Clear bit reads 0
      REG_THRESH: rd_data = WB_DAT_W'(cfg.threshold);
      REG_ENERGY: rd_data = WB_DAT_W'(cfg.energy);
      REG_STATUS: begin
        rd_data[STAT_DET_BIT] = cfg.detected;
        rd_data[STAT_FCNT_LSB +: FCNT_W] = cfg.frame_count;
      end
      default:    rd_data = '0;
    endcase
  end

  // Read data registered alongside ack
  always_ff @(posedge clk_m) begin
    if (req) wb_dat_r <= rd_data;
  end

  // Ack only ever answers a request seen one cycle earlier
  assert property (@(posedge clk_m) disable iff (sys_rst)
    wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

`default_nettype wire

// File: hdl/audio_detect_top.sv
`default_nettype none

module audio_detect_top
  import audio_pkg::*;
#(
  parameter int SCK_DIV   = 4,
  parameter int FRAME_LEN = 512
) (
  input  wire                 clk_m,
  input  wire                 sys_rst,

  input  wire                 mic_data,
  output logic                mic_sck,
  output logic                mic_ws,

  output logic                pdm_out,  // Playback stream

  output logic                detected,
  output logic                frame_irq,

  input  wire                 wb_cyc,
  input  wire                 wb_stb,
  input  wire                 wb_we,
  input  wire [WB_ADR_W-1:0]  wb_adr,
  input  wire [WB_DAT_W-1:0]  wb_dat_w,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack
);

  logic signed [SAMPLE_W-1:0] sample;
  logic                       sample_valid;

  detect_cfg_if cfg_bus ();

  // Microphone capture
  mic_i2s_rx #(
    .SCK_DIV(SCK_DIV)
  ) u_mic (
    .clk_m       (clk_m),
    .sys_rst     (sys_rst),
    .mic_data    (mic_data),
    .mic_sck     (mic_sck),
    .mic_ws      (mic_ws),
    .sample      (sample),
    .sample_valid(sample_valid)
  );

  pdm_mod u_pdm (
    .clk_m       (clk_m),
    .sys_rst     (sys_rst),
    .sample      (sample),
    .sample_valid(sample_valid),
    .pdm_out     (pdm_out)
  );

  frame_energy #(
    .FRAME_LEN(FRAME_LEN)
  ) u_energy (
    .clk_m       (clk_m),
    .sys_rst     (sys_rst),
    .sample      (sample),
    .sample_valid(sample_valid),
    .cfg         (cfg_bus.det)
  );

  // Host access
  wb_regs u_regs (
    .clk_m   (clk_m),
    .sys_rst (sys_rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .cfg     (cfg_bus.regs)
  );

  assign detected  = cfg_bus.detected;
  assign frame_irq = cfg_bus.frame_done;

endmodule

`default_nettype wire

// File: verification/tb_audio_detect.sv
`default_nettype none

module tb_audio_detect
  import audio_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_LEN   = 8;
  localparam int CYCLE_LIMIT = 120000;  // 12 frames of 4096 cycles plus margin, doubled

  logic                clk_m;
  logic                sys_rst  = 1'b1;
  logic                mic_data = 1'b0;
  logic                wb_cyc   = 1'b0;
  logic                wb_stb   = 1'b0;
  logic                wb_we    = 1'b0;
  logic [WB_ADR_W-1:0] wb_adr   = '0;
  logic [WB_DAT_W-1:0] wb_dat_w = '0;
  logic                mic_sck;
  logic                mic_ws;
  logic                pdm_out;
  logic                detected;
  logic                frame_irq;
  logic                wb_ack;
  logic [WB_DAT_W-1:0] wb_dat_r;

  logic [15:0]         lfsr = 16'd42124;
  logic [SAMPLE_W-1:0] frame_q[$];  // Samples waiting for the microphone
  logic [SAMPLE_W-1:0] sent_q[$];   // Shifted out, not yet part of a checked frame
  logic [FCNT_W-1:0]   model_fcnt = '0;
  int                  cycles = 0;

  audio_detect_top #(
    .SCK_DIV  (4),
    .FRAME_LEN(FRAME_LEN)
  ) UUT (.*);

  initial begin
    clk_m = 1'b0;
    forever #20 clk_m = ~clk_m;
  end

  always @(posedge clk_m) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("TESTS FAILED");
      $fatal(1, "Run did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) w = {w[30:0], lfsr_bit()};
    return w;
  endfunction

  // Magnitude of a signed PCM sample, -32768 gives 32768
  function automatic logic [31:0] abs_sample(input logic [SAMPLE_W-1:0] s);
    int v;
    v = int'($signed(s));
    return (v < 0) ? 32'(-v) : 32'(v);
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  // Classic single access, master holds the request until ack
  task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WB_DAT_W-1:0] wdat,
                           output logic [WB_DAT_W-1:0] rdat);
    @(posedge clk_m);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    @(posedge clk_m);
    while (!wb_ack) @(posedge clk_m);
    rdat = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(posedge clk_m);
    check("ack is one cycle", 32'd0, 32'(wb_ack));
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
    logic [WB_DAT_W-1:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_expect(input string name, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] expected);
    logic [WB_DAT_W-1:0] rdat;
    wb_access(1'b0, adr, '0, rdat);
    check(name, expected, rdat);
  endtask

  task automatic wait_frame_irq();
    @(posedge clk_m);
    while (!frame_irq) @(posedge clk_m);
  endtask

  // Right slot start lies between a sample strobe and the next left slot
  task automatic wait_ws_rise();
    logic prev;
    prev = mic_ws;
    @(posedge clk_m);
    while (!(mic_ws && !prev)) begin
      prev = mic_ws;
      @(posedge clk_m);
    end
  endtask

  task automatic clear_frames(input logic en);
    wb_write(REG_CTRL, {30'd0, 1'b1, en});
    sent_q.delete();
    model_fcnt = '0;
  endtask

  task automatic fill_frame(output logic [31:0] sum);
    logic [SAMPLE_W-1:0] s;
    sum = '0;
    repeat (FRAME_LEN) begin
      s = SAMPLE_W'(rand_word(SAMPLE_W));
      frame_q.push_back(s);
      sum += abs_sample(s);
    end
  endtask

  task automatic run_frame(input logic en, input logic [31:0] thr);
    logic [31:0] sum;
    logic        det;
    wait_frame_irq();
    check("samples in frame", FRAME_LEN, 32'(sent_q.size()));
    sum = '0;
    while (sent_q.size() > 0) sum += abs_sample(sent_q.pop_front());
    det = en && (sum > thr);
    model_fcnt++;
    check("detected output", 32'(det), 32'(detected));
    read_expect("frame energy", REG_ENERGY, sum);
    read_expect("status", REG_STATUS, {16'd0, model_fcnt, 7'd0, det});
  endtask

  // I2S microphone and playback density monitor
  int                  slot_idx;
  logic                sck_q;
  logic                ws_q;
  logic                pdm_q;
  logic                win_open;
  logic [SAMPLE_W-1:0] cur;
  logic [15:0]         level;
  int                  ones;
  int                  exp_ones;
  int                  allowed;

  always @(posedge clk_m) begin
    if (sys_rst) begin
      slot_idx = 0;
      sck_q    = 1'b0;
      ws_q     = 1'b0;
      pdm_q    = 1'b0;
      win_open = 1'b0;
      ones     = 0;
      mic_data <= 1'b0;
    end else begin
      if (sck_q && !mic_sck) begin  // Falling sck edge just passed
        slot_idx = (ws_q && !mic_ws) ? 0 : slot_idx + 1;
        if (!mic_ws && slot_idx == 1) begin
          if (frame_q.size() > 0) cur = frame_q.pop_front();
          else cur = SAMPLE_W'(rand_word(SAMPLE_W));
          sent_q.push_back(cur);
        end
        if (!mic_ws && slot_idx >= 1 && slot_idx <= SAMPLE_W)
          mic_data <= cur[4'(SAMPLE_W - slot_idx)];  // MSB first
        else
          mic_data <= lfsr_bit();  // Bits the DUT ignores
        if (!mic_ws && slot_idx == SAMPLE_W + 1) begin
          if (win_open) begin
            exp_ones = (int'(level) * 512) / 65536;
            // Allow +-2 for period alignment
            allowed  = (ones < exp_ones - 2) ? exp_ones - 2 :
                       (ones > exp_ones + 2) ? exp_ones + 2 : ones;
            check("pdm ones per sample period", 32'(allowed), 32'(ones));
          end
          level    = cur ^ 16'h8000;  // Offset binary
          ones     = 0;
          win_open = 1'b1;
        end
      end
      if (win_open) ones += int'(pdm_q);
      pdm_q = pdm_out;  // One cycle late, so the window holds a single level
      sck_q = mic_sck;
      ws_q  = mic_ws;
    end
  end

  initial begin
    logic [31:0] thr;
    logic [31:0] sum;
    logic        en;

    repeat (3) @(posedge clk_m);
    sys_rst <= 1'b0;
    check("reset outputs", 32'd0,
          32'({mic_sck, mic_ws, pdm_out, detected, frame_irq, wb_ack}));
    read_expect("reset ctrl", REG_CTRL, '0);
    read_expect("reset thresh", REG_THRESH, '0);
    read_expect("reset energy", REG_ENERGY, '0);
    read_expect("reset status", REG_STATUS, '0);

    repeat (4) begin
      thr = rand_word(32);
      wb_write(REG_THRESH, thr);
      read_expect("threshold readback", REG_THRESH, thr);
    end
    wb_write(REG_CTRL, 32'h3);
    read_expect("ctrl clear bit", REG_CTRL, 32'h1);
    wb_write(REG_CTRL, 32'h0);
    wb_write(REG_ENERGY, 32'hFFFF_FFFF);
    wb_write(REG_STATUS, 32'hFFFF_FFFF);
    read_expect("energy read-only", REG_ENERGY, '0);
    read_expect("status read-only", REG_STATUS, '0);
    for (int a = 4; a < 16; a++) begin
      wb_write(WB_ADR_W'(a), rand_word(32));
      read_expect("unmapped address", WB_ADR_W'(a), '0);
    end

    wait_ws_rise();
    clear_frames(1'b1);  // Frame boundaries now line up with the model
    for (int f = 0; f < 7; f++) begin
      fill_frame(sum);
      en  = (f % 4) != 3;
      thr = sum + 32'(f % 3) - 32'd1;  // Below, at and above the sum
      wb_write(REG_THRESH, thr);
      wb_write(REG_CTRL, {31'd0, en});
      run_frame(en, thr);
    end

    // Clear three samples into a frame
    repeat (4) wait_ws_rise();
    check("samples before clear", 32'd3, 32'(sent_q.size()));
    clear_frames(1'b1);
    check("detected after clear", 32'd0, 32'(detected));
    read_expect("status after clear", REG_STATUS, '0);
    read_expect("ctrl after clear", REG_CTRL, 32'h1);
    fill_frame(sum);
    thr = sum - 32'd1;
    wb_write(REG_THRESH, thr);
    run_frame(1'b1, thr);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/audio_pkg.sv
hdl/detect_cfg_if.sv
hdl/mic_i2s_rx.sv
hdl/pdm_mod.sv
hdl/frame_energy.sv
hdl/wb_regs.sv
hdl/audio_detect_top.sv
verification/tb_audio_detect.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, then run it
cd "$(dirname "$0")" \
  && verilator --binary --assert -j 0 -f project.f --top-module tb_audio_detect \
  && ./obj_dir/Vtb_audio_detect \
  || { echo "Simulation build or run failed"; exit 1; }
exit 0
